// File: hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

   localparam int ADDR_BITS = 11;     // Word addresses.
   localparam int MEM_DEPTH = 2048;
   localparam int DATA_BITS = 32;
   localparam int REG_BITS  = 5;

   // AND r1,r1,r1 used as the pipeline bubble.
   localparam logic [DATA_BITS-1:0] NOP_WORD = 32'h0021_0824;

   // Primary opcode field, bits 31:26.
   localparam logic [5:0] OPC_RTYPE = 6'h00;
   localparam logic [5:0] OPC_BEQ   = 6'h04;
   localparam logic [5:0] OPC_ADDI  = 6'h08;

   // Funct field of R-type words, bits 5:0.
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUBU = 6'h23;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_XOR  = 6'h26;
   localparam logic [5:0] FN_SLT  = 6'h2a;

   typedef enum logic [3:0] {
      OP_NOP, OP_ADDU, OP_SUBU, OP_AND, OP_OR,
      OP_XOR, OP_SLT, OP_ADDI, OP_BEQ
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
   } alu_op_e;

endpackage

`default_nettype wire

// File: hw/decoded_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decoded_if;
   import mips_pkg::*;

   logic                 valid;      // A real instruction sits in ID/EX.
   opcode_e              op;
   alu_op_e              alu_op;
   logic [DATA_BITS-1:0] rs_val;
   logic [DATA_BITS-1:0] rt_val;
   logic [DATA_BITS-1:0] imm;        // Already sign extended.
   logic [REG_BITS-1:0]  dest;
   logic                 we;
   logic [ADDR_BITS-1:0] pc_plus1;

   modport src (
      output valid, op, alu_op, rs_val, rt_val, imm, dest, we, pc_plus1
   );

   modport dst (
      input valid, op, alu_op, rs_val, rt_val, imm, dest, we, pc_plus1
   );

endinterface

`default_nettype wire

// File: hw/program_memory.sv
`timescale 1ns/1ps
`default_nettype none

module program_memory (
   input  wire                             i_clock,
   input  wire  [mips_pkg::ADDR_BITS-1:0]  i_addr,
   input  wire                             i_we,
   input  wire  [mips_pkg::DATA_BITS-1:0]  i_wdata,
   input  wire                             i_hold,
   input  wire                             i_insert_nop,
   input  wire                             i_soft_reset,
   output logic [mips_pkg::DATA_BITS-1:0]  o_rdata
);
   import mips_pkg::*;

   logic [DATA_BITS-1:0] mem [MEM_DEPTH];

   always_ff @(posedge i_clock) begin
      if (i_we) begin
         mem[i_addr] <= i_wdata;
      end
   end

   // The read register doubles as the IF/ID instruction register.
   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         o_rdata <= NOP_WORD;
      end else if (!i_hold) begin
         if (i_insert_nop) begin
            o_rdata <= NOP_WORD;       // Squashed slot.
         end else begin
            o_rdata <= mem[i_addr];
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
   input  wire                             i_clock,
   input  wire                             i_soft_reset,
   input  wire                             i_run,
   input  wire                             i_load_we,
   input  wire  [mips_pkg::ADDR_BITS-1:0]  i_load_addr,
   input  wire  [mips_pkg::DATA_BITS-1:0]  i_load_data,
   input  wire                             i_branch_taken,
   input  wire  [mips_pkg::ADDR_BITS-1:0]  i_branch_target,
   output logic [mips_pkg::DATA_BITS-1:0]  o_instruction,
   output logic [mips_pkg::ADDR_BITS-1:0]  o_pc_plus1,
   output logic [mips_pkg::ADDR_BITS-1:0]  o_pc
);
   import mips_pkg::*;

   logic [ADDR_BITS-1:0] pc_q;
   logic [ADDR_BITS-1:0] mem_addr;
   logic [ADDR_BITS-1:0] next_addr;

   // Load port while stopped, then branch target over the PC.
   always_comb begin
      if (!i_run) begin
         mem_addr = i_load_addr;
      end else if (i_branch_taken) begin
         mem_addr = i_branch_target;   // Target is read this very cycle.
      end else begin
         mem_addr = pc_q;
      end
   end

   assign next_addr = mem_addr + ADDR_BITS'(1);

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         pc_q       <= '0;
         o_pc_plus1 <= ADDR_BITS'(1);
      end else if (i_run) begin
         pc_q       <= next_addr;
         o_pc_plus1 <= next_addr;      // Travels with the fetched word.
      end
   end

   assign o_pc = pc_q;

   program_memory u_program_memory (
      .i_clock      (i_clock),
      .i_addr       (mem_addr),
      .i_we         (i_load_we && !i_run),
      .i_wdata      (i_load_data),
      .i_hold       (!i_run),
      .i_insert_nop (1'b0),            // Decode voids the squashed slot.
      .i_soft_reset (i_soft_reset),
      .o_rdata      (o_instruction)
   );

endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  wire                             i_clock,
   input  wire                             i_soft_reset,
   input  wire  [mips_pkg::REG_BITS-1:0]   i_rs,
   input  wire  [mips_pkg::REG_BITS-1:0]   i_rt,
   input  wire                             i_we,
   input  wire  [mips_pkg::REG_BITS-1:0]   i_wreg,
   input  wire  [mips_pkg::DATA_BITS-1:0]  i_wdata,
   output logic [mips_pkg::DATA_BITS-1:0]  o_rs_val,
   output logic [mips_pkg::DATA_BITS-1:0]  o_rt_val
);
   import mips_pkg::*;

   logic [DATA_BITS-1:0] regs [2**REG_BITS];

   // Zero for r0, the incoming write on a match, else storage.
   function automatic logic [DATA_BITS-1:0] read_port(input logic [REG_BITS-1:0] idx);
      if (idx == '0) begin
         return '0;
      end else if (i_we && (i_wreg == idx)) begin
         return i_wdata;
      end
      return regs[idx];
   endfunction

   always_comb begin
      o_rs_val = read_port(i_rs);
      o_rt_val = read_port(i_rt);
   end

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         for (int i = 0; i < 2**REG_BITS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && (i_wreg != '0)) begin
         regs[i_wreg] <= i_wdata;
      end
   end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  wire                             i_clock,
   input  wire                             i_soft_reset,
   input  wire                             i_run,
   input  wire  [mips_pkg::DATA_BITS-1:0]  i_instruction,
   input  wire  [mips_pkg::ADDR_BITS-1:0]  i_pc_plus1,
   input  wire                             i_branch_taken,
   input  wire                             i_wb_we,
   input  wire  [mips_pkg::REG_BITS-1:0]   i_wb_reg,
   input  wire  [mips_pkg::DATA_BITS-1:0]  i_wb_data,
   decoded_if.src                          o_dec
);
   import mips_pkg::*;

   logic [5:0]           opcode;
   logic [5:0]           funct;
   logic [REG_BITS-1:0]  rs;
   logic [REG_BITS-1:0]  rt;
   logic [REG_BITS-1:0]  rd;
   opcode_e              op;
   alu_op_e              alu_op;
   logic [REG_BITS-1:0]  dest;
   logic                 writes;
   logic                 we;
   logic [DATA_BITS-1:0] rs_val;
   logic [DATA_BITS-1:0] rt_val;
   logic                 ir_live_q;    // IR holds a fetched word, not the reset NOP.

   assign opcode = i_instruction[31:26];
   assign rs     = i_instruction[25:21];
   assign rt     = i_instruction[20:16];
   assign rd     = i_instruction[15:11];
   assign funct  = i_instruction[5:0];

   always_comb begin
      op     = OP_NOP;
      alu_op = ALU_ADD;
      dest   = rd;
      writes = 1'b0;
      case (opcode)
         OPC_RTYPE: begin
            writes = 1'b1;
            case (funct)
               FN_ADDU: begin op = OP_ADDU; alu_op = ALU_ADD; end
               FN_SUBU: begin op = OP_SUBU; alu_op = ALU_SUB; end
               FN_AND:  begin op = OP_AND;  alu_op = ALU_AND; end
               FN_OR:   begin op = OP_OR;   alu_op = ALU_OR;  end
               FN_XOR:  begin op = OP_XOR;  alu_op = ALU_XOR; end
               FN_SLT:  begin op = OP_SLT;  alu_op = ALU_SLT; end
               default: writes = 1'b0;     // Unknown funct.
            endcase
         end
         OPC_ADDI: begin
            op     = OP_ADDI;
            dest   = rt;
            writes = 1'b1;
         end
         OPC_BEQ: begin
            op     = OP_BEQ;
            alu_op = ALU_SUB;
         end
         default: ;
      endcase
      we = writes && (dest != '0);         // r0 writes never leave EX.
   end

   register_file u_register_file (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_rs         (rs),
      .i_rt         (rt),
      .i_we         (i_wb_we),
      .i_wreg       (i_wb_reg),
      .i_wdata      (i_wb_data),
      .o_rs_val     (rs_val),
      .o_rt_val     (rt_val)
   );

   always_ff @(posedge i_clock) begin
      if (!i_soft_reset) begin
         ir_live_q   <= 1'b0;
         o_dec.valid <= 1'b0;
         o_dec.op    <= OP_NOP;
         o_dec.we    <= 1'b0;
      end else if (i_run) begin
         ir_live_q   <= 1'b1;
         o_dec.valid <= ir_live_q && !i_branch_taken;   // Bubble on a taken branch.
         o_dec.op    <= op;
         o_dec.we    <= we;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_run) begin
         o_dec.alu_op   <= alu_op;
         o_dec.rs_val   <= rs_val;
         o_dec.rt_val   <= rt_val;
         o_dec.imm      <= {{(DATA_BITS-16){i_instruction[15]}}, i_instruction[15:0]};
         o_dec.dest     <= dest;
         o_dec.pc_plus1 <= i_pc_plus1;
      end
   end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   decoded_if.dst                          i_dec,
   output logic                            o_wb_we,
   output logic [mips_pkg::REG_BITS-1:0]   o_wb_reg,
   output logic [mips_pkg::DATA_BITS-1:0]  o_wb_data,
   output logic                            o_branch_taken,
   output logic [mips_pkg::ADDR_BITS-1:0]  o_branch_target
);
   import mips_pkg::*;

   logic [DATA_BITS-1:0] operand_a;
   logic [DATA_BITS-1:0] operand_b;
   logic [DATA_BITS-1:0] alu_result;

   assign operand_a = i_dec.rs_val;

   // ADDI takes the immediate, everything else the rt value.
   assign operand_b = (i_dec.op == OP_ADDI) ? i_dec.imm : i_dec.rt_val;

   always_comb begin
      case (i_dec.alu_op)
         ALU_ADD: alu_result = operand_a + operand_b;
         ALU_SUB: alu_result = operand_a - operand_b;
         ALU_AND: alu_result = operand_a & operand_b;
         ALU_OR:  alu_result = operand_a | operand_b;
         ALU_XOR: alu_result = operand_a ^ operand_b;
         ALU_SLT: begin
            // Signed compare.
            alu_result = ($signed(operand_a) < $signed(operand_b)) ?
                         DATA_BITS'(1) : '0;
         end
         default: alu_result = '0;
      endcase
   end

   // BEQ resolves here, one slot behind it is lost.
   always_comb begin
      o_branch_taken  = i_dec.valid && (i_dec.op == OP_BEQ) &&
                        (i_dec.rs_val == i_dec.rt_val);
      o_branch_target = i_dec.pc_plus1 + i_dec.imm[ADDR_BITS-1:0];   // Word offset.
   end

   assign o_wb_we   = i_dec.valid && i_dec.we;
   assign o_wb_reg  = i_dec.dest;
   assign o_wb_data = alu_result;

endmodule

`default_nettype wire

// File: hw/mips_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_top (
   input  wire                             i_clock,
   input  wire                             i_soft_reset,
   input  wire                             i_run,
   input  wire                             i_load_we,
   input  wire  [mips_pkg::ADDR_BITS-1:0]  i_load_addr,
   input  wire  [mips_pkg::DATA_BITS-1:0]  i_load_data,
   output logic                            o_wb_we,
   output logic [mips_pkg::REG_BITS-1:0]   o_wb_reg,
   output logic [mips_pkg::DATA_BITS-1:0]  o_wb_data,
   output logic [mips_pkg::ADDR_BITS-1:0]  o_pc
);
   import mips_pkg::*;

   logic [DATA_BITS-1:0] instruction;
   logic [ADDR_BITS-1:0] pc_plus1;
   logic                 branch_taken;
   logic [ADDR_BITS-1:0] branch_target;
   logic                 ex_wb_we;

   decoded_if u_dec_if ();

   fetch_stage u_fetch_stage (
      .i_clock         (i_clock),
      .i_soft_reset    (i_soft_reset),
      .i_run           (i_run),
      .i_load_we       (i_load_we),
      .i_load_addr     (i_load_addr),
      .i_load_data     (i_load_data),
      .i_branch_taken  (branch_taken),
      .i_branch_target (branch_target),
      .o_instruction   (instruction),
      .o_pc_plus1      (pc_plus1),
      .o_pc            (o_pc)
   );

   decode_stage u_decode_stage (
      .i_clock        (i_clock),
      .i_soft_reset   (i_soft_reset),
      .i_run          (i_run),
      .i_instruction  (instruction),
      .i_pc_plus1     (pc_plus1),
      .i_branch_taken (branch_taken),
      .i_wb_we        (o_wb_we),
      .i_wb_reg       (o_wb_reg),
      .i_wb_data      (o_wb_data),
      .o_dec          (u_dec_if.src)
   );

   execute_stage u_execute_stage (
      .i_dec           (u_dec_if.dst),
      .o_wb_we         (ex_wb_we),
      .o_wb_reg        (o_wb_reg),
      .o_wb_data       (o_wb_data),
      .o_branch_taken  (branch_taken),
      .o_branch_target (branch_target)
   );

   assign o_wb_we = ex_wb_we && i_run;   // No write lands while stalled.

endmodule

`default_nettype wire

// File: sim/mips_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_properties (
   input wire                             i_clock,
   input wire                             i_soft_reset,
   input wire                             i_run,
   input wire                             i_branch_taken,
   input wire [mips_pkg::ADDR_BITS-1:0]   i_branch_target,
   input wire                             i_dec_valid,
   input wire                             i_wb_we,
   input wire [mips_pkg::ADDR_BITS-1:0]   i_pc
);
   import mips_pkg::*;

   // A taken branch sends the PC one word past its target.
   a_pc_follows_branch: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      (i_branch_taken && i_run) |=> (i_pc == $past(i_branch_target) + ADDR_BITS'(1)))
      else $error("PC did not move past the branch target after a taken branch");

   a_bubble_after_branch: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      (i_branch_taken && i_run) |=> !i_dec_valid)
      else $error("ID/EX is not a bubble after a taken branch");

   // First cycle out of reset writes nothing.
   a_no_write_after_reset: assert property (@(posedge i_clock)
      !i_soft_reset |=> !i_wb_we)
      else $error("register write in the cycle after reset");

   a_pc_holds_when_stalled: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      !i_run |=> $stable(i_pc))
      else $error("PC moved while the core was stalled");

endmodule

bind mips_core_top mips_core_properties u_properties (
   .i_clock         (i_clock),
   .i_soft_reset    (i_soft_reset),
   .i_run           (i_run),
   .i_branch_taken  (branch_taken),
   .i_branch_target (branch_target),
   .i_dec_valid     (u_dec_if.valid),
   .i_wb_we         (ex_wb_we),
   .i_pc            (o_pc)
);

`default_nettype wire

// File: sim/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
   import mips_pkg::*;

   localparam int          CLK_PERIOD   = 40;
   localparam int          NUM_PROGRAMS = 6;
   localparam int          MAX_STEPS    = 600;    // Executed instructions per program.
   localparam int          WATCHDOG_NS  = CLK_PERIOD * NUM_PROGRAMS * (MAX_STEPS * 3 + 100);
   localparam logic [31:0] SEED         = 32'he3d71cf3;

   logic                 i_clock;
   logic                 i_soft_reset;
   logic                 i_run;
   logic                 i_load_we;
   logic [ADDR_BITS-1:0] i_load_addr;
   logic [DATA_BITS-1:0] i_load_data;
   logic                 o_wb_we;
   logic [REG_BITS-1:0]  o_wb_reg;
   logic [DATA_BITS-1:0] o_wb_data;
   logic [ADDR_BITS-1:0] o_pc;

   logic [DATA_BITS-1:0] prog [MEM_DEPTH];
   int                   prog_len;
   logic [31:0]          rng_state;
   logic [REG_BITS-1:0]  exp_reg [$];         // Expected writes in program order.
   logic [DATA_BITS-1:0] exp_data [$];
   int                   exp_idx;
   logic                 check_en;

   mips_core_top dut (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_run        (i_run),
      .i_load_we    (i_load_we),
      .i_load_addr  (i_load_addr),
      .i_load_data  (i_load_data),
      .o_wb_we      (o_wb_we),
      .o_wb_reg     (o_wb_reg),
      .o_wb_data    (o_wb_data),
      .o_pc         (o_pc)
   );

   always #(CLK_PERIOD / 2) i_clock = ~i_clock;

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "run stopped on the first error");
   endtask

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = next_rand();
      return int'(r[30:8]) % n;               // Low LCG bits are weak.
   endfunction

   function automatic logic [REG_BITS-1:0] rand_reg(input int lo, input int hi);
      return REG_BITS'(lo + rand_below(hi - lo + 1));
   endfunction

   function automatic logic [15:0] rand_imm();
      return 16'(rand_below(65536));
   endfunction

   function automatic logic [5:0] pick_funct(input int k);
      case (k)
         0:       return FN_ADDU;
         1:       return FN_SUBU;
         2:       return FN_AND;
         3:       return FN_OR;
         4:       return FN_XOR;
         default: return FN_SLT;
      endcase
   endfunction

   function automatic logic [DATA_BITS-1:0] enc_r(input logic [5:0] fn,
         input logic [REG_BITS-1:0] rd, input logic [REG_BITS-1:0] rs,
         input logic [REG_BITS-1:0] rt);
      return {OPC_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [DATA_BITS-1:0] enc_i(input logic [5:0] opc,
         input logic [REG_BITS-1:0] rs, input logic [REG_BITS-1:0] rt, input logic [15:0] imm);
      return {opc, rs, rt, imm};
   endfunction

   function automatic void emit(input logic [DATA_BITS-1:0] word);
      prog[ADDR_BITS'(prog_len)] = word;
      prog_len++;
   endfunction

   // One R-type or ADDI with its destination in dlo..dhi.
   function automatic void emit_alu(input int dlo, input int dhi);
      int                  kind;
      logic [REG_BITS-1:0] d;
      logic [REG_BITS-1:0] s;
      logic [REG_BITS-1:0] t;
      kind = rand_below(7);
      d = rand_reg(dlo, dhi);
      s = rand_reg(1, 7);
      t = rand_reg(1, 7);
      if (kind == 6) begin
         emit(enc_i(OPC_ADDI, s, d, rand_imm()));
      end else begin
         emit(enc_r(pick_funct(kind), d, s, t));
      end
   endfunction

   function automatic void gen_program();
      int                  k;
      int                  start;
      logic [REG_BITS-1:0] a;
      logic [REG_BITS-1:0] b;
      logic [31:0]         r;
      prog_len = 0;
      emit_alu(1, 7);                         // These read registers that reset cleared.
      emit_alu(1, 7);
      for (int i = 1; i < 8; i++) begin
         emit(enc_i(OPC_ADDI, 5'd0, REG_BITS'(i), rand_imm()));
      end
      k = 6 + rand_below(6);
      for (int blk = 0; blk < k; blk++) begin
         case (rand_below(6))
            0, 1: emit_alu(1, 7);
            2: begin                          // Result used by the next two.
               a = rand_reg(1, 7);
               b = rand_reg(1, 7);
               emit(enc_i(OPC_ADDI, a, a, rand_imm()));
               emit(enc_r(pick_funct(rand_below(6)), b, a, a));
               emit(enc_r(pick_funct(rand_below(6)), rand_reg(1, 7), a, b));
            end
            3: begin                          // Forward BEQ over 1 to 3 words.
               a = rand_reg(1, 7);
               b = (rand_below(2) == 0) ? a : rand_reg(1, 7);
               start = 1 + rand_below(3);
               emit(enc_i(OPC_BEQ, a, b, 16'(start)));
               repeat (start) emit_alu(1, 7);
            end
            4: begin                          // Counted loop on r7.
               emit(enc_i(OPC_ADDI, 5'd0, 5'd7, 16'(1 + rand_below(3))));
               start = prog_len;
               repeat (1 + rand_below(3)) emit_alu(1, 6);
               emit(enc_i(OPC_ADDI, 5'd7, 5'd7, 16'hffff));
               emit(enc_i(OPC_BEQ, 5'd7, 5'd0, 16'd1));
               emit(enc_i(OPC_BEQ, 5'd0, 5'd0, 16'(start - prog_len - 1)));
            end
            default: begin
               if (rand_below(2) == 0) begin
                  r = next_rand();
                  emit({6'(16 + rand_below(16)), r[25:0]});   // Unknown opcode.
                  emit(enc_r(6'(48 + rand_below(8)), rand_reg(1, 7), rand_reg(1, 7),
                             rand_reg(1, 7)));
               end else begin
                  emit_alu(0, 0);             // Write to r0, then read it back.
                  emit(enc_r(FN_OR, rand_reg(1, 7), 5'd0, rand_reg(1, 7)));
               end
            end
         endcase
      end
      emit(enc_i(OPC_BEQ, 5'd0, 5'd0, 16'hffff));   // Halt loop.
   endfunction

   // Instruction set model. Fills the expected write queues, returns the step count.
   function automatic int run_reference(input logic [DATA_BITS-1:0] code [MEM_DEPTH]);
      logic [DATA_BITS-1:0] rf [32];
      logic [DATA_BITS-1:0] w;
      logic [DATA_BITS-1:0] a;
      logic [DATA_BITS-1:0] b;
      logic [DATA_BITS-1:0] imm;
      logic [DATA_BITS-1:0] res;
      logic [ADDR_BITS-1:0] pc;
      logic [ADDR_BITS-1:0] next_pc;
      logic [REG_BITS-1:0]  dst;
      logic                 wr;
      int                   steps;
      rf = '{default: '0};
      exp_reg.delete();
      exp_data.delete();
      pc = '0;
      steps = 0;
      while (steps < MAX_STEPS) begin
         w = code[pc];
         a = rf[w[25:21]];
         b = rf[w[20:16]];
         imm = {{16{w[15]}}, w[15:0]};
         dst = w[15:11];
         wr = 1'b0;
         res = '0;
         next_pc = pc + ADDR_BITS'(1);
         steps++;
         case (w[31:26])
            OPC_RTYPE: begin
               wr = 1'b1;
               case (w[5:0])
                  FN_ADDU: res = a + b;
                  FN_SUBU: res = a - b;
                  FN_AND:  res = a & b;
                  FN_OR:   res = a | b;
                  FN_XOR:  res = a ^ b;
                  FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: wr = 1'b0;
               endcase
            end
            OPC_ADDI: begin
               wr = 1'b1;
               dst = w[20:16];
               res = a + imm;
            end
            OPC_BEQ: begin
               if (a == b) begin
                  if (next_pc + imm[ADDR_BITS-1:0] == pc) begin
                     return steps;            // Reached the halt loop.
                  end
                  next_pc = next_pc + imm[ADDR_BITS-1:0];
               end
            end
            default: ;
         endcase
         if (wr && (dst != '0)) begin
            rf[dst] = res;
            exp_reg.push_back(dst);
            exp_data.push_back(res);
         end
         pc = next_pc;
      end
      return steps;
   endfunction

   task automatic check_reg(input logic [REG_BITS-1:0] got, input logic [REG_BITS-1:0] want,
         input int idx);
      if (got !== want) begin
         stop_run($sformatf("[ERROR] %0d ns: write %0d went to r%0d, expected r%0d",
                            $time, idx, got, want));
      end
   endtask

   task automatic check_data(input logic [DATA_BITS-1:0] got,
         input logic [DATA_BITS-1:0] want, input int idx);
      if (got !== want) begin
         stop_run($sformatf("[ERROR] %0d ns: write %0d data %h, expected %h",
                            $time, idx, got, want));
      end
   endtask

   task automatic check_pc(input logic [ADDR_BITS-1:0] got, input logic [ADDR_BITS-1:0] want);
      if (got !== want) begin
         stop_run($sformatf("[ERROR] %0d ns: PC %0d moved during a stall, held %0d",
                            $time, got, want));
      end
   endtask

   // Compare process. Outputs are stable at the rising edge since inputs move on the falling one.
   always @(posedge i_clock) begin
      if (check_en && o_wb_we) begin
         if (exp_idx >= exp_reg.size()) begin
            stop_run($sformatf("Unexpected extra write to r%0d at %0d ns", o_wb_reg, $time));
         end else begin
            check_reg(o_wb_reg, exp_reg[exp_idx], exp_idx);
            check_data(o_wb_data, exp_data[exp_idx], exp_idx);
            exp_idx++;
         end
      end
   end

   task automatic apply_reset();
      @(negedge i_clock);
      i_run = 1'b0;
      i_soft_reset = 1'b0;
      repeat (2) @(negedge i_clock);
      i_soft_reset = 1'b1;
   endtask

   task automatic load_program();
      for (int i = 0; i < prog_len; i++) begin
         i_load_we = 1'b1;
         i_load_addr = ADDR_BITS'(i);
         i_load_data = prog[ADDR_BITS'(i)];
         @(negedge i_clock);
      end
      i_load_we = 1'b0;
   endtask

   task automatic run_program(input bit with_stalls);
      logic [ADDR_BITS-1:0] pc_hold;
      i_run = 1'b1;
      while (exp_idx < exp_reg.size()) begin
         @(negedge i_clock);
         if (with_stalls && (rand_below(4) == 0)) begin
            i_run = 1'b0;
            pc_hold = o_pc;
            repeat (1 + rand_below(3)) begin
               @(negedge i_clock);
               check_pc(o_pc, pc_hold);
            end
            i_run = 1'b1;
         end
      end
      repeat (20) @(negedge i_clock);        // Halt loop must stay silent.
      i_run = 1'b0;
   endtask

   initial begin
      #(WATCHDOG_NS);
      stop_run("Timeout: the programs did not finish within the watchdog limit");
   end

   initial begin
      int steps;
      i_clock = 1'b0;
      i_soft_reset = 1'b0;
      i_run = 1'b0;
      i_load_we = 1'b0;
      i_load_addr = '0;
      i_load_data = '0;
      rng_state = SEED;
      check_en = 1'b0;
      exp_idx = 0;
      prog_len = 0;
      for (int p = 0; p < NUM_PROGRAMS; p++) begin
         gen_program();
         steps = run_reference(prog);
         if (steps >= MAX_STEPS) begin
            stop_run("The reference model did not reach the halt loop");
         end
         apply_reset();                       // Each program starts from cleared registers.
         load_program();
         exp_idx = 0;
         check_en = 1'b1;
         run_program(p >= 2);
         check_en = 1'b0;
      end
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
hw/mips_pkg.sv
hw/decoded_if.sv
hw/program_memory.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mips_core_top.sv
sim/mips_core_properties.sv
sim/tb_mips_core.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the run fails.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module tb_mips_core \
   -Mdir build -o tb_mips_core &&
./build/tb_mips_core ||
{ echo "Simulation did not pass"; exit 1; }
